//--- sources.f
design/calc_pkg.sv
design/calc_issue.sv
design/calc_pipe_int.sv
design/calc_pipe_mul.sv
design/calc_pipe_long.sv
design/calc_completion.sv
design/calc_top.sv
test/calc_tb.sv

//--- Bender.yml
package:
  name: calc

sources:
  - design/calc_pkg.sv
  - design/calc_issue.sv
  - design/calc_pipe_int.sv
  - design/calc_pipe_mul.sv
  - design/calc_pipe_long.sv
  - design/calc_completion.sv
  - design/calc_top.sv
  - target: test
    files:
      - test/calc_tb.sv

//--- test/calc_tb.sv
/*
  Calculator testbench
  Directed and random dispatch against a program-order reference model,
  fixed-slot and in-order long writeback checks with credit tracking
*/
`timescale 1ns/100ps

module calc_tb;

  localparam int NUM_REGS   = 1 << calc_pkg::REG_ADDR_WIDTH;
  localparam int EXP_SLOTS  = 8;
  // Drive edge to the edge that samples the writeback
  localparam int WB_LATENCY = 5;
  localparam int RANDOM_OPS = 400;
  localparam int WAIT_LIMIT = 400;

  logic                    clk_i;
  logic                    rst_i;
  calc_pkg::dispatch_pkt_t dispatch_i;
  calc_pkg::wb_pkt_t       wb_o;
  logic                    long_credit_o;

  logic [calc_pkg::DATA_WIDTH-1:0] prog_rf [NUM_REGS];
  logic [calc_pkg::DATA_WIDTH-1:0] lag_rf [NUM_REGS];
  int                              ready_cyc [NUM_REGS];
  logic                            long_busy [NUM_REGS];
  logic                            exp_v [EXP_SLOTS];
  calc_pkg::wb_pkt_t               exp_wb [EXP_SLOTS];
  calc_pkg::wb_pkt_t               long_fifo [$];
  int                              cyc;
  int                              credits;
  integer                          seed;
  logic                            dispatched;

  calc_top uut
    (
      .clk_i         (clk_i)
    , .rst_i         (rst_i)
    , .dispatch_i    (dispatch_i)
    , .wb_o          (wb_o)
    , .long_credit_o (long_credit_o)
    );

  initial clk_i = 1'b0;
  always #10 clk_i = ~clk_i;

  task automatic stop_on_failure();
    $display("Simulation finished: FAIL");
    $fatal(1, "Stopped at the first failed check");
  endtask

  task automatic report_mismatch(string name, logic [31:0] got, logic [31:0] want);
    $display("CHECK FAILED %s got 0x%08h expected 0x%08h at cycle %0d", name, got, want, cyc);
    stop_on_failure();
  endtask

  task automatic report_error(string what);
    $display("ERROR %s at cycle %0d", what, cyc);
    stop_on_failure();
  endtask

  function automatic int urand(int n);
    return $unsigned($random(seed)) % n;
  endfunction

  function automatic logic is_long(calc_pkg::op_e op);
    return (op == calc_pkg::DIVU) || (op == calc_pkg::REMU);
  endfunction

  // Reference results straight from the instruction definitions
  function automatic logic [31:0] model_result(calc_pkg::op_e op, logic [31:0] a, logic [31:0] b);
    logic [31:0] r;
    case (op)
      calc_pkg::ADD:  r = a + b;
      calc_pkg::SUB:  r = a - b;
      calc_pkg::AND:  r = a & b;
      calc_pkg::OR:   r = a | b;
      calc_pkg::XOR:  r = a ^ b;
      calc_pkg::SLL:  r = a << b[4:0];
      calc_pkg::SRL:  r = a >> b[4:0];
      calc_pkg::SLT:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      calc_pkg::MUL:  r = a * b;
      calc_pkg::DIVU: r = (b == 0) ? 32'hffff_ffff : a / b;
      calc_pkg::REMU: r = (b == 0) ? a : a % b;
      default:        r = '0;
    endcase
    return r;
  endfunction

  function automatic logic slots_pending();
    for (int i = 0; i < EXP_SLOTS; i++)
    begin
      if (exp_v[i])
        return 1'b1;
    end
    return 1'b0;
  endfunction

  // Compares wb_o with the write due at this edge, else with the long FIFO head
  task automatic check_writeback();
    int                slot;
    calc_pkg::wb_pkt_t want;
    slot = cyc % EXP_SLOTS;
    if (exp_v[slot])
    begin
      want        = exp_wb[slot];
      exp_v[slot] = 1'b0;
      assert (wb_o.rd_w_v === 1'b1) else report_mismatch("wb_o.rd_w_v", 32'(wb_o.rd_w_v), 1);
      assert (long_credit_o === 1'b0) else report_mismatch("long_credit_o", 32'(long_credit_o), 0);
      assert (wb_o.rd_addr === want.rd_addr)
        else report_mismatch("wb_o.rd_addr", 32'(wb_o.rd_addr), 32'(want.rd_addr));
      assert (wb_o.rd_data === want.rd_data)
        else report_mismatch("wb_o.rd_data", wb_o.rd_data, want.rd_data);
      lag_rf[wb_o.rd_addr] = wb_o.rd_data;
    end
    else if (long_credit_o === 1'b1)
    begin
      assert (long_fifo.size() > 0)
        else report_error("long credit returned with no long operation outstanding");
      want = long_fifo.pop_front();
      assert (wb_o.rd_w_v === 1'b1) else report_mismatch("wb_o.rd_w_v", 32'(wb_o.rd_w_v), 1);
      assert (wb_o.rd_addr === want.rd_addr)
        else report_mismatch("wb_o.rd_addr", 32'(wb_o.rd_addr), 32'(want.rd_addr));
      assert (wb_o.rd_data === want.rd_data)
        else report_mismatch("wb_o.rd_data", wb_o.rd_data, want.rd_data);
      lag_rf[wb_o.rd_addr]    = wb_o.rd_data;
      long_busy[wb_o.rd_addr] = 1'b0;
      credits++;
      assert (credits <= calc_pkg::LONG_CREDITS)
        else report_error("more long credits returned than were spent");
    end
    else
    begin
      assert (wb_o.rd_w_v === 1'b0) else report_error("write on wb_o where none was expected");
      assert (long_credit_o === 1'b0) else report_mismatch("long_credit_o", 32'(long_credit_o), 0);
    end
  endtask

  task automatic tick();
    @(posedge clk_i);
    cyc++;
    if (cyc > 1)
      check_writeback();
  endtask

  task automatic drive_idle();
    dispatch_i <= '0;
  endtask

  task automatic drive_op(calc_pkg::op_e op, int rd, int rs1, int rs2, logic wen);
    calc_pkg::dispatch_pkt_t pkt;
    calc_pkg::wb_pkt_t       wr;
    pkt          = '0;
    pkt.v        = 1'b1;
    pkt.op       = op;
    pkt.rd_addr  = calc_pkg::REG_ADDR_WIDTH'(rd);
    pkt.rd_w_v   = wen;
    pkt.rs1_addr = calc_pkg::REG_ADDR_WIDTH'(rs1);
    pkt.rs2_addr = calc_pkg::REG_ADDR_WIDTH'(rs2);
    // Operands come from the lagging register file and are often stale
    pkt.rs1      = lag_rf[rs1];
    pkt.rs2      = lag_rf[rs2];
    wr.rd_w_v    = 1'b1;
    wr.rd_addr   = pkt.rd_addr;
    wr.rd_data   = model_result(op, prog_rf[rs1], prog_rf[rs2]);
    if (is_long(op))
    begin
      long_fifo.push_back(wr);
      long_busy[rd] = 1'b1;
      credits--;
    end
    else if (wen && (rd != 0))
    begin
      exp_v[(cyc + WB_LATENCY) % EXP_SLOTS]  = 1'b1;
      exp_wb[(cyc + WB_LATENCY) % EXP_SLOTS] = wr;
      ready_cyc[rd] = (op == calc_pkg::MUL) ? cyc + 3 : cyc + 1;
    end
    if (wen && (rd != 0))
      prog_rf[rd] = wr.rd_data;
    dispatch_i <= pkt;
    dispatched  = 1'b1;
  endtask

  task automatic send_op(calc_pkg::op_e op, int rd, int rs1, int rs2);
    tick();
    drive_op(op, rd, rs1, rs2, 1'b1);
  endtask

  task automatic send_idle(int n);
    repeat (n)
    begin
      tick();
      drive_idle();
    end
  endtask

  task automatic send_long(calc_pkg::op_e op, int rd, int rs1, int rs2);
    int waited;
    waited = 0;
    // Dispatcher holds back while all long credits are spent
    while (credits == 0)
    begin
      send_idle(1);
      waited++;
      if (waited > WAIT_LIMIT)
        report_error("timed out waiting for a long credit");
    end
    send_op(op, rd, rs1, rs2);
  endtask

  task automatic wait_long_done(int rd);
    int waited;
    waited = 0;
    while (long_busy[rd])
    begin
      send_idle(1);
      waited++;
      if (waited > WAIT_LIMIT)
        report_error("timed out waiting for a long result");
    end
  endtask

  function automatic int pick_source();
    int r;
    for (int i = 0; i < 8; i++)
    begin
      r = urand(NUM_REGS);
      if (!long_busy[r] && (cyc >= ready_cyc[r]))
        return r;
    end
    return 0;
  endfunction

  function automatic int pick_dest();
    int r;
    for (int i = 0; i < 8; i++)
    begin
      r = urand(NUM_REGS);
      if (!long_busy[r])
        return r;
    end
    return 0;
  endfunction

  task automatic random_step();
    int            kind;
    int            rd;
    int            rs1;
    int            rs2;
    calc_pkg::op_e op;
    tick();
    kind = urand(16);
    rd   = pick_dest();
    rs1  = pick_source();
    rs2  = pick_source();
    if (kind < 3)
      drive_idle();
    else if (kind < 5)
    begin
      op = (urand(2) == 0) ? calc_pkg::DIVU : calc_pkg::REMU;
      if ((credits > 0) && (rd != 0))
        drive_op(op, rd, rs1, rs2, 1'b1);
      else
        drive_idle();
    end
    else
    begin
      op = (kind < 8) ? calc_pkg::MUL : calc_pkg::op_e'(urand(8));
      drive_op(op, rd, rs1, rs2, urand(16) != 0);
    end
  endtask

  task automatic drain_pending();
    int waited;
    waited = 0;
    while ((long_fifo.size() > 0) || slots_pending())
    begin
      send_idle(1);
      waited++;
      if (waited > WAIT_LIMIT)
        report_error("expected writeback never appeared during the final drain");
    end
  endtask

  a_quiet_write : assert property (@(posedge clk_i)
    ((cyc >= 1) && !dispatched) |-> (wb_o.rd_w_v === 1'b0))
    else report_mismatch("wb_o.rd_w_v", 32'($sampled(wb_o.rd_w_v)), 0);

  a_quiet_credit : assert property (@(posedge clk_i)
    ((cyc >= 1) && !dispatched) |-> (long_credit_o === 1'b0))
    else report_mismatch("long_credit_o", 32'($sampled(long_credit_o)), 0);

  a_credit_with_write : assert property (@(posedge clk_i) disable iff (rst_i)
    long_credit_o |-> wb_o.rd_w_v)
    else report_mismatch("wb_o.rd_w_v", 32'($sampled(wb_o.rd_w_v)), 1);

  initial
  begin
    seed       = 32'h3567887d;
    cyc        = 0;
    credits    = calc_pkg::LONG_CREDITS;
    dispatched = 1'b0;
    rst_i      = 1'b1;
    dispatch_i = '0;
    for (int i = 0; i < NUM_REGS; i++)
    begin
      lag_rf[i]    = (i == 0) ? '0 : (32'h9e37_79b9 * i) ^ (i << 27);
      prog_rf[i]   = lag_rf[i];
      ready_cyc[i] = 0;
      long_busy[i] = 1'b0;
    end
    for (int i = 0; i < EXP_SLOTS; i++)
      exp_v[i] = 1'b0;

    send_idle(2);
    rst_i <= 1'b0;
    send_idle(3);

    // Every ALU operation once
    for (int i = 0; i < 8; i++)
      send_op(calc_pkg::op_e'(i), 20 + i, i + 1, i + 9);

    // Consumers 1 to 4 cycles behind their producer
    // Each producer changes r6 so the operand the DUT receives is stale
    for (int gap = 1; gap <= 4; gap++)
    begin
      send_op(calc_pkg::ADD, 6, 6, 7);
      send_idle(gap - 1);
      send_op(calc_pkg::ADD, 9, 6, 6);
    end
    send_op(calc_pkg::ADD, 1, 2, 3);
    send_op(calc_pkg::SUB, 1, 1, 4);
    send_op(calc_pkg::AND, 5, 1, 2);

    // Three products in flight, first one consumed three cycles later
    send_op(calc_pkg::MUL, 14, 11, 12);
    send_op(calc_pkg::MUL, 15, 12, 3);
    send_op(calc_pkg::MUL, 16, 3, 4);
    send_op(calc_pkg::ADD, 13, 14, 11);
    send_idle(4);

    // Third long operation has to stall for a credit
    send_op(calc_pkg::ADD, 25, 1, 0);
    send_long(calc_pkg::DIVU, 17, 18, 25);
    send_long(calc_pkg::REMU, 19, 18, 12);
    send_long(calc_pkg::DIVU, 21, 22, 0);
    send_long(calc_pkg::REMU, 23, 22, 0);
    wait_long_done(23);
    send_op(calc_pkg::ADD, 24, 23, 21);
    send_idle(4);

    repeat (RANDOM_OPS)
      random_step();
    drain_pending();
    send_idle(2);

    assert (credits == calc_pkg::LONG_CREDITS)
      else report_mismatch("long credits", credits, calc_pkg::LONG_CREDITS);
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

//--- design/calc_top.sv
/*
  Calculator top
  Issue stage, ALU, multiply and divide pipes and the completion pipe
*/
`timescale 1ns/100ps

module calc_top
  (
    input  logic                    clk_i
  , input  logic                    rst_i
  , input  calc_pkg::dispatch_pkt_t dispatch_i
  , output calc_pkg::wb_pkt_t       wb_o
  , output logic                    long_credit_o
  );

  calc_pkg::dispatch_pkt_t                       reservation;
  calc_pkg::fu_res_t                             int_res;
  calc_pkg::fu_res_t                             mul_res;
  calc_pkg::wb_pkt_t                             long_res;
  logic                                          long_res_v;
  logic                                          long_yumi;
  calc_pkg::wb_pkt_t [calc_pkg::COMP_STAGES-1:0] fwd;

  calc_issue issue
    (
      .clk_i         (clk_i)
    , .rst_i         (rst_i)
    , .dispatch_i    (dispatch_i)
    , .fwd_i         (fwd)
    , .reservation_o (reservation)
    );

  calc_pipe_int pipe_int
    (
      .reservation_i (reservation)
    , .res_o         (int_res)
    );

  calc_pipe_mul pipe_mul
    (
      .clk_i         (clk_i)
    , .rst_i         (rst_i)
    , .reservation_i (reservation)
    , .res_o         (mul_res)
    );

  calc_pipe_long pipe_long
    (
      .clk_i         (clk_i)
    , .rst_i         (rst_i)
    , .reservation_i (reservation)
    , .res_o         (long_res)
    , .res_v_o       (long_res_v)
    , .res_yumi_i    (long_yumi)
    );

  calc_completion completion
    (
      .clk_i         (clk_i)
    , .rst_i         (rst_i)
    , .reservation_i (reservation)
    , .int_res_i     (int_res)
    , .mul_res_i     (mul_res)
    , .long_res_i    (long_res)
    , .long_res_v_i  (long_res_v)
    , .long_yumi_o   (long_yumi)
    , .fwd_o         (fwd)
    , .wb_o          (wb_o)
    , .long_credit_o (long_credit_o)
    );

endmodule

//--- design/calc_completion.sv
/*
  Completion pipe
  Shifts destinations toward writeback, merges pipe results at fixed stages,
  feeds the bypass network and slots long results into idle writebacks
*/
`timescale 1ns/100ps

module calc_completion
  (
    input  logic                                          clk_i
  , input  logic                                          rst_i
  , input  calc_pkg::dispatch_pkt_t                       reservation_i
  , input  calc_pkg::fu_res_t                             int_res_i
  , input  calc_pkg::fu_res_t                             mul_res_i
  , input  calc_pkg::wb_pkt_t                             long_res_i
  , input  logic                                          long_res_v_i
  , output logic                                          long_yumi_o
  , output calc_pkg::wb_pkt_t [calc_pkg::COMP_STAGES-1:0] fwd_o
  , output calc_pkg::wb_pkt_t                             wb_o
  , output logic                                          long_credit_o
  );

  localparam int LAST = calc_pkg::COMP_STAGES - 1;

  calc_pkg::wb_pkt_t             stage0;
  calc_pkg::wb_pkt_t [LAST:1]    stage_n;
  calc_pkg::wb_pkt_t [LAST:1]    stage_r;

  // Stage 0 is the reservation itself
  // Long operations write back through the long port instead
  assign stage0.rd_w_v  = reservation_i.v & reservation_i.rd_w_v &
                          (reservation_i.rd_addr != '0) &
                          (calc_pkg::op_pipe(reservation_i.op) != calc_pkg::PIPE_LONG);
  assign stage0.rd_addr = reservation_i.rd_addr;
  assign stage0.rd_data = '0;

  // Single issue with fixed latencies, so each result ORs into an empty data slot
  always_comb
  begin
    stage_n[1] = stage0;
    for (int i = 2; i <= LAST; i++)
      stage_n[i] = stage_r[i-1];
    stage_n[calc_pkg::INT_STAGE].rd_data |= int_res_i.v ? int_res_i.data : '0;
    stage_n[calc_pkg::MUL_STAGE].rd_data |= mul_res_i.v ? mul_res_i.data : '0;
  end

  always_ff @(posedge clk_i)
  begin
    stage_r <= stage_n;
    if (rst_i)
    begin
      for (int i = 1; i <= LAST; i++)
        stage_r[i].rd_w_v <= 1'b0;
    end
  end

  // Bypass view pairs each stage's destination with the data it holds next cycle
  always_comb
  begin
    fwd_o[0]         = stage0;
    fwd_o[0].rd_data = stage_n[1].rd_data;
    for (int i = 1; i < LAST; i++)
    begin
      fwd_o[i]         = stage_r[i];
      fwd_o[i].rd_data = stage_n[i+1].rd_data;
    end
    fwd_o[LAST] = stage_r[LAST];
  end

  // Last stage always wins the port, long results fill the gaps
  assign long_yumi_o   = long_res_v_i & ~stage_r[LAST].rd_w_v;
  assign long_credit_o = long_yumi_o;
  assign wb_o          = long_yumi_o ? long_res_i : stage_r[LAST];

  // A product lands on an entry that carries no ALU data
  a_no_result_overlap : assert property (@(posedge clk_i) disable iff (rst_i)
    mul_res_i.v |-> (stage_r[calc_pkg::MUL_STAGE-1].rd_data == '0));

endmodule

//--- design/calc_pipe_long.sv
/*
  Long pipe
  One waiting slot in front of a restoring divider for DIVU and REMU,
  result held until the completion side accepts it
*/
`timescale 1ns/100ps

module calc_pipe_long
  (
    input  logic                    clk_i
  , input  logic                    rst_i
  , input  calc_pkg::dispatch_pkt_t reservation_i
  , output calc_pkg::wb_pkt_t       res_o
  , output logic                    res_v_o
  , input  logic                    res_yumi_i
  );

  calc_pkg::dispatch_pkt_t                slot_r;
  logic                                   long_in;
  logic                                   div_free;
  logic                                   div_start;
  logic                                   div_busy_r;
  logic                                   div_done_r;
  logic [calc_pkg::LOG2_DATA_WIDTH-1:0]   div_cnt_r;
  calc_pkg::op_e                          div_op_r;
  logic [calc_pkg::REG_ADDR_WIDTH-1:0]    div_rd_addr_r;
  logic                                   div_rd_w_v_r;
  logic [calc_pkg::DATA_WIDTH-1:0]        div_quo_r;
  logic [calc_pkg::DATA_WIDTH-1:0]        div_rem_r;
  logic [calc_pkg::DATA_WIDTH-1:0]        div_den_r;
  logic [calc_pkg::DATA_WIDTH:0]          rem_shift;
  logic [calc_pkg::DATA_WIDTH:0]          rem_diff;

  assign long_in = reservation_i.v &&
                   (calc_pkg::op_pipe(reservation_i.op) == calc_pkg::PIPE_LONG);

  // Divider frees up in the same cycle its result is taken
  assign div_free  = ~div_busy_r & (~div_done_r | res_yumi_i);
  assign div_start = slot_r.v & div_free;

  always_ff @(posedge clk_i)
  begin
    if (long_in)
      slot_r <= reservation_i;
    else if (div_start)
      slot_r.v <= 1'b0;
    if (rst_i)
      slot_r.v <= 1'b0;
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      div_busy_r <= 1'b0;
      div_done_r <= 1'b0;
    end
    else if (div_start)
    begin
      div_busy_r <= 1'b1;
      div_done_r <= 1'b0;
    end
    else if (div_busy_r && (div_cnt_r == '0))
    begin
      div_busy_r <= 1'b0;
      div_done_r <= 1'b1;
    end
    else if (res_yumi_i)
      div_done_r <= 1'b0;
  end

  // One quotient bit per cycle, dividend shifts out of the quotient register
  assign rem_shift = {div_rem_r, div_quo_r[calc_pkg::DATA_WIDTH-1]};
  assign rem_diff  = rem_shift - {1'b0, div_den_r};

  always_ff @(posedge clk_i)
  begin
    if (div_start)
    begin
      div_op_r      <= slot_r.op;
      div_rd_addr_r <= slot_r.rd_addr;
      div_rd_w_v_r  <= slot_r.rd_w_v;
      div_quo_r     <= slot_r.rs1;
      div_den_r     <= slot_r.rs2;
      div_rem_r     <= '0;
      div_cnt_r     <= calc_pkg::LOG2_DATA_WIDTH'(calc_pkg::DATA_WIDTH-1);
    end
    else if (div_busy_r)
    begin
      div_cnt_r <= div_cnt_r - 1'b1;
      div_quo_r <= {div_quo_r[calc_pkg::DATA_WIDTH-2:0], ~rem_diff[calc_pkg::DATA_WIDTH]};
      if (rem_diff[calc_pkg::DATA_WIDTH])
        div_rem_r <= rem_shift[calc_pkg::DATA_WIDTH-1:0];
      else
        div_rem_r <= rem_diff[calc_pkg::DATA_WIDTH-1:0];
    end
  end

  // A zero divisor always subtracts, giving all ones and the dividend as remainder
  assign res_o.rd_w_v  = div_rd_w_v_r & (div_rd_addr_r != '0);
  assign res_o.rd_addr = div_rd_addr_r;
  assign res_o.rd_data = (div_op_r == calc_pkg::REMU) ? div_rem_r : div_quo_r;
  assign res_v_o       = div_done_r;

  // Credit limit keeps the slot and divider from both being taken on arrival
  a_long_capacity : assert property (@(posedge clk_i) disable iff (rst_i)
    long_in |-> (!slot_r.v || div_free));

  a_long_hold : assert property (@(posedge clk_i) disable iff (rst_i)
    (res_v_o && !res_yumi_i) |=> (res_v_o && $stable(res_o)));

endmodule

//--- design/calc_pipe_mul.sv
/*
  Multiply pipe
  Two register stages forming the low word of the product
*/
`timescale 1ns/100ps

module calc_pipe_mul
  (
    input  logic                    clk_i
  , input  logic                    rst_i
  , input  calc_pkg::dispatch_pkt_t reservation_i
  , output calc_pkg::fu_res_t       res_o
  );

  logic                            mul_in;
  logic                            pp_v_r;
  logic [calc_pkg::DATA_WIDTH-1:0] pp_lo_r;
  logic [calc_pkg::DATA_WIDTH-1:0] pp_hi_r;
  logic                            prod_v_r;
  logic [calc_pkg::DATA_WIDTH-1:0] prod_r;

  assign mul_in = reservation_i.v &&
                  (calc_pkg::op_pipe(reservation_i.op) == calc_pkg::PIPE_MUL);

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      pp_v_r   <= 1'b0;
      prod_v_r <= 1'b0;
    end
    else
    begin
      pp_v_r   <= mul_in;
      prod_v_r <= pp_v_r;
    end
  end

  // First stage splits the multiplier into two halves
  always_ff @(posedge clk_i)
  begin
    pp_lo_r <= reservation_i.rs1 * reservation_i.rs2[calc_pkg::HALF_WIDTH-1:0];
    pp_hi_r <= reservation_i.rs1 * reservation_i.rs2[calc_pkg::DATA_WIDTH-1:calc_pkg::HALF_WIDTH];
    // Second stage aligns the upper partial product and sums
    prod_r  <= pp_lo_r + (pp_hi_r << calc_pkg::HALF_WIDTH);
  end

  assign res_o.v    = prod_v_r;
  assign res_o.data = prod_r;

endmodule

//--- design/calc_pipe_int.sv
/*
  Integer ALU pipe
  Single-cycle add, subtract, logic, shift and signed compare
*/
`timescale 1ns/100ps

module calc_pipe_int
  (
    input  calc_pkg::dispatch_pkt_t reservation_i
  , output calc_pkg::fu_res_t       res_o
  );

  logic [calc_pkg::DATA_WIDTH-1:0]      src1;
  logic [calc_pkg::DATA_WIDTH-1:0]      src2;
  logic [calc_pkg::LOG2_DATA_WIDTH-1:0] shamt;
  logic                                 lt;
  logic [calc_pkg::DATA_WIDTH-1:0]      result;

  assign src1  = reservation_i.rs1;
  assign src2  = reservation_i.rs2;
  assign shamt = src2[calc_pkg::LOG2_DATA_WIDTH-1:0];
  assign lt    = $signed(src1) < $signed(src2);

  always_comb
  begin
    case (reservation_i.op)
      calc_pkg::ADD: result = src1 + src2;
      calc_pkg::SUB: result = src1 - src2;
      calc_pkg::AND: result = src1 & src2;
      calc_pkg::OR:  result = src1 | src2;
      calc_pkg::XOR: result = src1 ^ src2;
      calc_pkg::SLL: result = src1 << shamt;
      calc_pkg::SRL: result = src1 >> shamt;
      calc_pkg::SLT: result = {{(calc_pkg::DATA_WIDTH-1){1'b0}}, lt};
      default:       result = '0;
    endcase
  end

  // Only int-class operations produce a result here
  assign res_o.v    = reservation_i.v &&
                      (calc_pkg::op_pipe(reservation_i.op) == calc_pkg::PIPE_INT);
  assign res_o.data = result;

endmodule

//--- design/calc_issue.sv
/*
  Issue stage
  Bypasses the newest in-flight results into the source operands
  and registers the dispatch packet into the reservation
*/
`timescale 1ns/100ps

module calc_issue
  (
    input  logic                                          clk_i
  , input  logic                                          rst_i
  , input  calc_pkg::dispatch_pkt_t                       dispatch_i
  , input  calc_pkg::wb_pkt_t [calc_pkg::COMP_STAGES-1:0] fwd_i
  , output calc_pkg::dispatch_pkt_t                       reservation_o
  );

  calc_pkg::dispatch_pkt_t reservation_n;
  calc_pkg::dispatch_pkt_t reservation_r;

  // Picks the youngest stage that writes the source register,
  // else keeps the operand read from the register file
  function automatic logic [calc_pkg::DATA_WIDTH-1:0] bypass
    (
      input logic [calc_pkg::REG_ADDR_WIDTH-1:0]           rs_addr
    , input logic [calc_pkg::DATA_WIDTH-1:0]               rs_data
    , input calc_pkg::wb_pkt_t [calc_pkg::COMP_STAGES-1:0] fwd
    );
    logic [calc_pkg::DATA_WIDTH-1:0] data;
    data = rs_data;
    // Walk from the oldest stage so a younger match overrides
    for (int i = calc_pkg::COMP_STAGES-1; i >= 0; i--)
    begin
      if (fwd[i].rd_w_v && (fwd[i].rd_addr == rs_addr))
        data = fwd[i].rd_data;
    end
    return data;
  endfunction

  always_comb
  begin
    reservation_n     = dispatch_i;
    reservation_n.rs1 = bypass(dispatch_i.rs1_addr, dispatch_i.rs1, fwd_i);
    reservation_n.rs2 = bypass(dispatch_i.rs2_addr, dispatch_i.rs2, fwd_i);
  end

  // Registered packet feeds all three pipes and the completion pipe
  always_ff @(posedge clk_i)
  begin
    reservation_r <= reservation_n;
    if (rst_i)
      reservation_r.v <= 1'b0;
  end

  assign reservation_o = reservation_r;

endmodule

//--- design/calc_pkg.sv
/*
  Calculator package
  Widths, opcodes, packet structs and the opcode to pipe mapping
  shared by the integer execution back end
*/
package calc_pkg;

  localparam int DATA_WIDTH      = 32;
  localparam int HALF_WIDTH      = DATA_WIDTH / 2;
  localparam int LOG2_DATA_WIDTH = $clog2(DATA_WIDTH);
  localparam int REG_ADDR_WIDTH  = 5;
  localparam int COMP_STAGES     = 4;
  localparam int INT_STAGE       = 1;
  localparam int MUL_STAGE       = 3;
  localparam int LONG_CREDITS    = 2;

  typedef enum logic [3:0]
  {
    ADD  = 4'd0,
    SUB  = 4'd1,
    AND  = 4'd2,
    OR   = 4'd3,
    XOR  = 4'd4,
    SLL  = 4'd5,
    SRL  = 4'd6,
    SLT  = 4'd7,
    MUL  = 4'd8,
    DIVU = 4'd9,
    REMU = 4'd10
  } op_e;

  // Execution pipe an opcode is steered to
  typedef enum logic [1:0]
  {
    PIPE_INT  = 2'd0,
    PIPE_MUL  = 2'd1,
    PIPE_LONG = 2'd2
  } pipe_e;

  typedef struct packed
  {
    logic                      v;
    op_e                       op;
    logic [REG_ADDR_WIDTH-1:0] rd_addr;
    logic                      rd_w_v;
    logic [REG_ADDR_WIDTH-1:0] rs1_addr;
    logic [REG_ADDR_WIDTH-1:0] rs2_addr;
    logic [DATA_WIDTH-1:0]     rs1;
    logic [DATA_WIDTH-1:0]     rs2;
  } dispatch_pkt_t;

  typedef struct packed
  {
    logic                      rd_w_v;
    logic [REG_ADDR_WIDTH-1:0] rd_addr;
    logic [DATA_WIDTH-1:0]     rd_data;
  } wb_pkt_t;

  typedef struct packed
  {
    logic                  v;
    logic [DATA_WIDTH-1:0] data;
  } fu_res_t;

  function automatic pipe_e op_pipe(op_e op);
    pipe_e pipe;
    case (op)
      MUL:        pipe = PIPE_MUL;
      DIVU, REMU: pipe = PIPE_LONG;
      default:    pipe = PIPE_INT;
    endcase
    return pipe;
  endfunction

endpackage
